// File: design/fdc_cfg.svh
// build-time configuration for the FDC command engine
// FDC_STEP_UNIT sets seek speed in clk_sys cycles, keep it small in simulation
// opcodes are compared on the low five bits only
`ifndef FDC_CFG_SVH
`define FDC_CFG_SVH

`define FDC_TRACKS          80      // cylinders on drive 0
`define FDC_STEP_UNIT       8       // cycles per step-rate unit

`define FDC_OPC_SPECIFY     5'h03
`define FDC_OPC_SENSE_DRIVE 5'h04
`define FDC_OPC_RECAL       5'h07
`define FDC_OPC_SENSE_INT   5'h08
`define FDC_OPC_SEEK        5'h0F

`define FDC_ST0_SEEK_END    8'h20
`define FDC_ST0_SEEK_ERR    8'hE8
`define FDC_ST0_INVALID     8'h80
`define FDC_ST3_ABSENT      8'h01   // drive 1 is never fitted

`endif

// File: design/fdc_pkg.sv
// shared types of the FDC command engine
// only the positioning and status commands are represented
package fdc_pkg;

	typedef logic [7:0] fdc_byte_t;

	// commands kept by the engine
	typedef enum logic [2:0] {
		OP_SPECIFY,
		OP_SENSE_DRIVE,
		OP_RECAL,
		OP_SENSE_INT,
		OP_SEEK,
		OP_INVALID
	} fdc_op_e;

	typedef struct packed {
		fdc_op_e   op;
		logic      drive;  // us0 of the drive/head byte
		logic      head;   // hd bit
		fdc_byte_t arg;    // ncn for seek, srt/hut byte for specify
	} fdc_cmd_t;

	typedef struct packed {
		logic [1:0] len;   // 1 or 2 bytes
		fdc_byte_t  b0;
		fdc_byte_t  b1;
	} fdc_result_t;

	// main status register, msb first as seen on the bus
	typedef struct packed {
		logic rqm;
		logic dio;
		logic exm;
		logic cb;
		logic d3;
		logic d2;
		logic d1;
		logic d0;
	} fdc_msr_t;

endpackage

// File: design/fdc_stream_if.sv
// valid/ready stream between the engine stages
// payload must stay stable from valid until the transfer cycle
`timescale 1ns/1ns

interface fdc_stream_if #(
	parameter type payload_t = logic [7:0]
);
	logic     valid;
	logic     ready;
	payload_t payload;

	// producer side
	modport src (output valid, output payload, input ready);

	// consumer side
	modport dst (input valid, input payload, output ready);

endinterface

// File: design/fdc_host_port.sv
// host side of the FDC, strobe protocol as on the original chip
// rd_n/wr_n are asynchronous and pass a two-flop synchroniser
// a strobe must stay low at least 3 clk_sys cycles, a0 and din stable meanwhile
`timescale 1ns/1ns

module fdc_host_port import fdc_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      a0,
	input  logic      rd_n,
	input  logic      wr_n,
	input  fdc_byte_t din,
	output fdc_byte_t dout,
	output logic      data_wr,
	output fdc_byte_t wr_byte,
	output logic      data_rd,
	input  fdc_byte_t res_byte,
	input  logic      cmd_busy,
	input  logic      res_active,
	input  logic      seeking
);
	logic [1:0] strb_s1, strb_s2, strb_s3; // {rd_n, wr_n}
	logic [1:0] a0_pipe;
	fdc_byte_t  din_s1, din_s2;
	logic       rd_ev, wr_ev;
	fdc_msr_t   msr;

	// ==================================================
	// strobe synchroniser and edge detect
	// ==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			strb_s1 <= 2'b11;
			strb_s2 <= 2'b11;
			strb_s3 <= 2'b11;
		end else begin
			strb_s1 <= {rd_n, wr_n};
			strb_s2 <= strb_s1;
			strb_s3 <= strb_s2;
		end
	end

	always_ff @(posedge clk_sys) begin
		a0_pipe <= {a0_pipe[0], a0}; // aligned with strb_s2
		din_s1  <= din;
		din_s2  <= din_s1;
	end

	assign rd_ev   = strb_s3[1] & ~strb_s2[1] & strb_s2[0]; // falling rd_n, wr_n high
	assign wr_ev   = strb_s3[0] & ~strb_s2[0] & strb_s2[1];
	assign data_wr = wr_ev & a0_pipe[1];
	assign data_rd = rd_ev & a0_pipe[1];
	assign wr_byte = din_s2;

	// ==================================================
	// main status register and read data
	// ==================================================
	always_comb begin
		msr     = '0;
		msr.rqm = ~seeking; // a held record only waits while a seek runs
		msr.dio = res_active;
		msr.cb  = cmd_busy | res_active;
		msr.d0  = seeking;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dout <= '0;
		end else if (rd_ev) begin
			if (!a0_pipe[1])
				dout <= msr;
			else if (res_active)
				dout <= res_byte;
			else
				dout <= 8'hFF; // data read outside result phase
		end
	end

	// host must never drive both strobes at once
	a_strobe_excl: assert property (@(posedge clk_sys) disable iff (!arst_n) rd_n || wr_n);

endmodule

// File: design/fdc_cmd_decode.sv
// command phase, opcode match and parameter-byte collection
// writes are dropped while a finished record waits for exec
// specify keeps only its first byte, hlt/nd is discarded
`timescale 1ns/1ns
`include "fdc_cfg.svh"

module fdc_cmd_decode import fdc_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      data_wr,
	input  fdc_byte_t wr_byte,
	output logic      cmd_busy,
	fdc_stream_if.src cmd
);
	fdc_op_e    op_dec;
	logic [1:0] n_param;
	logic [1:0] remain;  // parameter bytes still expected
	logic       valid_q;
	logic       opc_wr, par_wr;
	fdc_cmd_t   rec;

	// ==================================================
	// opcode table
	// ==================================================
	always_comb begin
		op_dec  = OP_INVALID;
		n_param = 2'd0;
		case (wr_byte[4:0])
			`FDC_OPC_SPECIFY:     begin op_dec = OP_SPECIFY;     n_param = 2'd2; end
			`FDC_OPC_SENSE_DRIVE: begin op_dec = OP_SENSE_DRIVE; n_param = 2'd1; end
			`FDC_OPC_RECAL:       begin op_dec = OP_RECAL;       n_param = 2'd1; end
			`FDC_OPC_SENSE_INT:   begin op_dec = OP_SENSE_INT;   n_param = 2'd0; end
			`FDC_OPC_SEEK:        begin op_dec = OP_SEEK;        n_param = 2'd2; end
			default: ;
		endcase
	end

	assign opc_wr = data_wr && !valid_q && (remain == 2'd0);
	assign par_wr = data_wr && !valid_q && (remain != 2'd0);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			remain  <= 2'd0;
			valid_q <= 1'b0;
		end else if (opc_wr) begin
			remain  <= n_param;
			valid_q <= (n_param == 2'd0); // sense int and invalid go straight out
		end else if (par_wr) begin
			remain <= remain - 2'd1;
			if (remain == 2'd1)
				valid_q <= 1'b1;
		end else if (valid_q && cmd.ready) begin
			valid_q <= 1'b0;
		end
	end

	// record fields
	always_ff @(posedge clk_sys) begin
		if (opc_wr) begin
			rec.op    <= op_dec;
			rec.drive <= 1'b0;
			rec.head  <= 1'b0;
			rec.arg   <= '0; // recal target
		end else if (par_wr) begin
			case (rec.op)
				OP_SPECIFY: if (remain == 2'd2) rec.arg <= wr_byte;
				OP_SEEK: begin
					if (remain == 2'd2) begin
						rec.drive <= wr_byte[0];
						rec.head  <= wr_byte[2];
					end else begin
						rec.arg <= wr_byte; // ncn
					end
				end
				default: begin
					rec.drive <= wr_byte[0];
					rec.head  <= wr_byte[2];
				end
			endcase
		end
	end

	assign cmd.valid   = valid_q;
	assign cmd.payload = rec;
	assign cmd_busy    = valid_q | (remain != 2'd0);

	a_rec_stable: assert property (@(posedge clk_sys) disable iff (!arst_n)
		cmd.valid && !cmd.ready |=> $stable(cmd.payload));

endmodule

// File: design/fdc_exec.sv
// execution phase, drive 0 state and the stepping seek engine
// seek always steps drive 0, the drive bit only matters for sense drive
// a seek to the present cylinder still costs one step period
`timescale 1ns/1ns
`include "fdc_cfg.svh"

module fdc_exec import fdc_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      drive_ready,
	fdc_stream_if.dst cmd,
	fdc_stream_if.src res,
	output logic      seeking
);
	localparam int STEP_MAX = 16 * `FDC_STEP_UNIT;
	localparam int TW       = $clog2(STEP_MAX + 1);

	fdc_cmd_t    cmd_in;
	fdc_result_t res_next, res_q;
	fdc_byte_t   pcn, ncn, st0, st3, tgt;
	logic [3:0]  srt;
	logic [TW-1:0] step_per, step_cnt;
	logic        int_pend, res_valid, cmd_fire, seek_ok, res_gen;

	assign cmd_in    = cmd.payload;
	assign cmd.ready = ~seeking & ~res_valid;
	assign cmd_fire  = cmd.valid & cmd.ready;

	assign step_per = TW'((5'd16 - {1'b0, srt}) * `FDC_STEP_UNIT);
	assign tgt      = (cmd_in.op == OP_RECAL) ? 8'd0 : cmd_in.arg;
	assign seek_ok  = (drive_ready && (tgt < `FDC_TRACKS)) || (tgt == 8'd0);
	assign st3      = {1'b0, ~drive_ready, drive_ready, (pcn == 8'd0), 1'b1, cmd_in.head, 2'b00};
	assign res_gen  = cmd_fire && !(cmd_in.op inside {OP_SPECIFY, OP_SEEK, OP_RECAL});

	// ==================================================
	// seek engine and interrupt state
	// ==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			seeking   <= 1'b0;
			int_pend  <= 1'b0;
			st0       <= '0;
			pcn       <= '0;
			ncn       <= '0;
			srt       <= '0; // slowest rate until specify
			step_cnt  <= '0;
			res_valid <= 1'b0;
		end else begin
			if (res_valid && res.ready)
				res_valid <= 1'b0;
			if (res_gen)
				res_valid <= 1'b1;
			if (seeking) begin
				if (step_cnt != '0) begin
					step_cnt <= step_cnt - 1'b1;
				end else if (pcn == ncn) begin
					seeking  <= 1'b0; // d0 drops with the interrupt
					st0      <= `FDC_ST0_SEEK_END;
					int_pend <= 1'b1;
				end else begin
					pcn      <= (pcn < ncn) ? pcn + 8'd1 : pcn - 8'd1;
					step_cnt <= step_per - 1'b1;
				end
			end
			if (cmd_fire) begin
				case (cmd_in.op)
					OP_SPECIFY: srt <= cmd_in.arg[7:4];
					OP_SEEK, OP_RECAL: begin
						if (seek_ok) begin
							seeking  <= 1'b1;
							ncn      <= tgt;
							int_pend <= 1'b0;
							step_cnt <= step_per - 1'b1;
						end else begin
							st0      <= `FDC_ST0_SEEK_ERR; // pcn kept
							int_pend <= 1'b1;
						end
					end
					OP_SENSE_INT: int_pend <= 1'b0;
					default: ;
				endcase
			end
		end
	end

	// result bytes
	always_comb begin
		res_next = '{len: 2'd1, b0: `FDC_ST0_INVALID, b1: 8'h00};
		case (cmd_in.op)
			OP_SENSE_INT:   if (int_pend) res_next = '{len: 2'd2, b0: st0, b1: pcn};
			OP_SENSE_DRIVE: res_next.b0 = cmd_in.drive ? `FDC_ST3_ABSENT : st3;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (res_gen)
			res_q <= res_next;
	end

	assign res.valid   = res_valid;
	assign res.payload = res_q;

	a_pcn_range: assert property (@(posedge clk_sys) disable iff (!arst_n) pcn < `FDC_TRACKS);

endmodule

// File: design/fdc_result.sv
// result phase, one or two bytes handed out on data reads
// a new result is taken only after the last byte of the previous one
`timescale 1ns/1ns

module fdc_result import fdc_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      data_rd,
	fdc_stream_if.dst res,
	output logic      res_active,
	output fdc_byte_t res_byte
);
	fdc_result_t res_in, held;
	logic        active;
	logic        idx;   // byte being presented
	logic        last;

	assign res_in    = res.payload;
	assign res.ready = ~active;
	assign last      = idx | (held.len != 2'd2);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			idx    <= 1'b0;
		end else if (res.valid && !active) begin
			active <= 1'b1;
			idx    <= 1'b0;
		end else if (active && data_rd) begin
			idx <= 1'b1;
			if (last)
				active <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (res.valid && !active)
			held <= res_in;
	end

	assign res_active = active;
	assign res_byte   = idx ? held.b1 : held.b0;

	a_res_len: assert property (@(posedge clk_sys) disable iff (!arst_n)
		res.valid && res.ready |-> res_in.len inside {2'd1, 2'd2});

endmodule

// File: design/fdc_top.sv
// FDC command engine top, host bus on plain ports
// only drive 0 is modelled, drive_ready stands for a fitted disk
`timescale 1ns/1ns

module fdc_top import fdc_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      a0,
	input  logic      rd_n,
	input  logic      wr_n,
	input  fdc_byte_t din,
	output fdc_byte_t dout,
	input  logic      drive_ready
);
	logic      data_wr, data_rd;
	fdc_byte_t wr_byte, res_byte;
	logic      cmd_busy, res_active, seeking;

	fdc_stream_if #(.payload_t(fdc_cmd_t))    cmd_if ();
	fdc_stream_if #(.payload_t(fdc_result_t)) res_if ();

	fdc_host_port host_port_inst (
		.clk_sys, .arst_n, .a0, .rd_n, .wr_n, .din, .dout,
		.data_wr, .wr_byte, .data_rd, .res_byte,
		.cmd_busy, .res_active, .seeking
	);

	fdc_cmd_decode cmd_decode_inst (
		.clk_sys, .arst_n, .data_wr, .wr_byte, .cmd_busy,
		.cmd (cmd_if)
	);

	fdc_exec exec_inst (
		.clk_sys, .arst_n, .drive_ready,
		.cmd (cmd_if),
		.res (res_if),
		.seeking
	);

	fdc_result result_inst (
		.clk_sys, .arst_n, .data_rd,
		.res (res_if),
		.res_active, .res_byte
	);

endmodule

// File: tb/fdc_clk_gen.sv
// clock and reset for the FDC testbench
// arst_n is released 1 ns after the last reset cycle's rising edge
`timescale 1ns/1ns

module fdc_clk_gen #(
	parameter int PERIOD_NS  = 8,
	parameter int RST_CYCLES = 4
) (
	output logic clk_sys,
	output logic arst_n
);
	initial clk_sys = 1'b0;
	always #(PERIOD_NS / 2) clk_sys = ~clk_sys;

	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_sys);
		#1 arst_n = 1'b1;
	end

endmodule

// File: tb/fdc_tb.sv
// table-driven testbench for the FDC command engine
// every access holds its strobe 3 clocks and then idles 3 clocks
// expected bytes assume drive 0 only and SPECIFY before the first seek
`timescale 1ns/1ns
`include "fdc_cfg.svh"

module fdc_tb import fdc_pkg::*; ();
	localparam int CLK_NS     = 8;
	localparam int MAX_ROWS   = 16;
	localparam int SEEK_CYC   = (`FDC_TRACKS + 1) * 16 * `FDC_STEP_UNIT; // slowest full stroke
	localparam int ROW_CYC    = 300;   // bus traffic of one row with idle gaps
	localparam int TIMEOUT_NS = MAX_ROWS * (SEEK_CYC + ROW_CYC) * CLK_NS;

	localparam int SPEC_SRT   = 'hD;   // step-rate nibble of the SPECIFY row
	localparam int STEP_CYC   = (16 - SPEC_SRT) * `FDC_STEP_UNIT;
	localparam int SEEK_SPAN  = 10;    // cylinders moved by each waited seek row
	localparam int POLL_SLACK = 40;    // msr polling latency

	localparam fdc_byte_t OPC_SPECIFY = {3'b000, `FDC_OPC_SPECIFY};
	localparam fdc_byte_t OPC_SENSE_DR = {3'b000, `FDC_OPC_SENSE_DRIVE};
	localparam fdc_byte_t OPC_RECAL   = {3'b000, `FDC_OPC_RECAL};
	localparam fdc_byte_t OPC_SENSE_I = {3'b000, `FDC_OPC_SENSE_INT};
	localparam fdc_byte_t OPC_SEEK    = {3'b000, `FDC_OPC_SEEK};

	typedef struct packed {
		logic [1:0]      n_cmd;
		logic [2:0][7:0] cmd;       // cmd[0] goes out first
		logic            rdy;       // drive_ready during the row
		logic            seek_wait; // poll d0 until the seek ends
		logic [1:0]      n_res;
		logic [1:0][7:0] res;
	} row_t;

	row_t rows [MAX_ROWS];
	int   n_rows;

	logic      clk_sys, arst_n;
	logic      a0, rd_n, wr_n, drive_ready;
	fdc_byte_t din, dout;

	fdc_clk_gen clk_gen_inst (.clk_sys, .arst_n);

	fdc_top fdc_top_inst (
		.clk_sys, .arst_n, .a0, .rd_n, .wr_n, .din, .dout, .drive_ready
	);

	// ==================================================
	// reporting and compare tasks
	// ==================================================
	task automatic abort_run(input string why);
		$display("Checks failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_byte(input string name, input fdc_byte_t got, input fdc_byte_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED t=%0t %s got %02h expected %02h", $time, name, got, exp);
			abort_run("result byte mismatch");
		end
	endtask

	task automatic check_msr(input string name, input fdc_msr_t got, input fdc_msr_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED t=%0t %s got %08b expected %08b", $time, name, got, exp);
			abort_run("main status register mismatch");
		end
	endtask

	// msr as the host should see it
	function automatic fdc_msr_t expect_msr(input logic rqm, input logic dio,
		input logic cb, input logic d0);
		fdc_msr_t m;
		m     = '0;
		m.rqm = rqm;
		m.dio = dio;
		m.cb  = cb;
		m.d0  = d0;
		return m;
	endfunction

	// ==================================================
	// host bus accesses
	// ==================================================
	task automatic write_reg(input logic addr, input fdc_byte_t data);
		int gap;
		gap = $urandom_range(5, 0);
		repeat (gap) @(posedge clk_sys);
		@(posedge clk_sys);
		#1;
		a0   = addr;
		din  = data;
		wr_n = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1 wr_n = 1'b1;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic read_reg(input logic addr, output fdc_byte_t data);
		int gap;
		gap = $urandom_range(5, 0);
		repeat (gap) @(posedge clk_sys);
		@(posedge clk_sys);
		#1;
		a0   = addr;
		rd_n = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1 rd_n = 1'b1;
		repeat (3) @(posedge clk_sys);
		#1 data = dout; // settled long before
	endtask

	// seek length must follow the SPECIFY step rate
	task automatic wait_seek_done();
		fdc_byte_t b;
		fdc_msr_t  m;
		time       t0;
		int        cyc;
		t0 = $time;
		read_reg(1'b0, b);
		check_msr("dout msr during seek", fdc_msr_t'(b), expect_msr(1'b0, 1'b0, 1'b0, 1'b1));
		m = fdc_msr_t'(b);
		while (m.d0) begin
			read_reg(1'b0, b);
			m = fdc_msr_t'(b);
		end
		cyc = int'(($time - t0) / CLK_NS);
		if (cyc < SEEK_SPAN * STEP_CYC || cyc > (SEEK_SPAN + 1) * STEP_CYC + POLL_SLACK)
			abort_run($sformatf("seek took %0d cycles, the step rate allows %0d to %0d",
				cyc, SEEK_SPAN * STEP_CYC, (SEEK_SPAN + 1) * STEP_CYC + POLL_SLACK));
	endtask

	// ==================================================
	// stimulus table
	// ==================================================
	task automatic add_row(input int n_cmd, input fdc_byte_t c0, input fdc_byte_t c1,
		input fdc_byte_t c2, input logic rdy, input logic seek_wait, input int n_res,
		input fdc_byte_t r0, input fdc_byte_t r1);
		row_t r;
		r.n_cmd     = 2'(n_cmd);
		r.cmd[0]    = c0;
		r.cmd[1]    = c1;
		r.cmd[2]    = c2;
		r.rdy       = rdy;
		r.seek_wait = seek_wait;
		r.n_res     = 2'(n_res);
		r.res[0]    = r0;
		r.res[1]    = r1;
		rows[n_rows] = r;
		n_rows++;
	endtask

	task automatic load_table();
		n_rows = 0;
		add_row(1, OPC_SENSE_I, 8'h00, 8'h00, 1'b1, 1'b0, 1, 8'h80, 8'h00); // nothing pending
		add_row(3, OPC_SPECIFY, fdc_byte_t'(SPEC_SRT << 4), 8'h02, 1'b1, 1'b0, 0,
			8'h00, 8'h00); // 3 units per step
		add_row(3, OPC_SEEK, 8'h00, 8'h0A, 1'b1, 1'b1, 0, 8'h00, 8'h00);
		add_row(1, OPC_SENSE_I, 8'h00, 8'h00, 1'b1, 1'b0, 2, 8'h20, 8'h0A);
		add_row(1, OPC_SENSE_I, 8'h00, 8'h00, 1'b1, 1'b0, 1, 8'h80, 8'h00);
		// one past the last cylinder
		add_row(3, OPC_SEEK, 8'h00, fdc_byte_t'(`FDC_TRACKS), 1'b1, 1'b0, 0, 8'h00, 8'h00);
		add_row(1, OPC_SENSE_I, 8'h00, 8'h00, 1'b1, 1'b0, 2, 8'hE8, 8'h0A);
		add_row(3, OPC_SEEK, 8'h00, 8'h05, 1'b0, 1'b0, 0, 8'h00, 8'h00);    // drive not ready
		add_row(1, OPC_SENSE_I, 8'h00, 8'h00, 1'b1, 1'b0, 2, 8'hE8, 8'h0A);
		add_row(2, OPC_RECAL, 8'h00, 8'h00, 1'b1, 1'b1, 0, 8'h00, 8'h00);
		add_row(1, OPC_SENSE_I, 8'h00, 8'h00, 1'b1, 1'b0, 2, 8'h20, 8'h00);
		add_row(2, OPC_SENSE_DR, 8'h04, 8'h00, 1'b1, 1'b0, 1, 8'h3C, 8'h00); // head 1
		add_row(2, OPC_SENSE_DR, 8'h01, 8'h00, 1'b1, 1'b0, 1, 8'h01, 8'h00); // drive 1
		add_row(1, 8'h1F, 8'h00, 8'h00, 1'b1, 1'b0, 1, 8'h80, 8'h00);       // undefined opcode
	endtask

	// ==================================================
	// main sequence and watchdog
	// ==================================================
	initial begin : main_seq
		fdc_byte_t b;
		row_t      r;
		a0          = 1'b0;
		rd_n        = 1'b1;
		wr_n        = 1'b1;
		din         = '0;
		drive_ready = 1'b1;
		void'($urandom(32'he490d25d));
		load_table();
		wait (arst_n == 1'b1);

		read_reg(1'b0, b);
		check_msr("dout msr after reset", fdc_msr_t'(b), expect_msr(1'b1, 1'b0, 1'b0, 1'b0));

		for (int i = 0; i < n_rows; i++) begin
			r = rows[i];
			@(posedge clk_sys);
			#1 drive_ready = r.rdy;
			for (int j = 0; j < int'(r.n_cmd); j++)
				write_reg(1'b1, r.cmd[j]);
			if (r.seek_wait)
				wait_seek_done();
			if (r.n_res != 2'd0) begin
				read_reg(1'b0, b); // result phase flags
				check_msr($sformatf("dout msr in result phase, row %0d", i), fdc_msr_t'(b),
					expect_msr(1'b1, 1'b1, 1'b1, 1'b0));
				for (int j = 0; j < int'(r.n_res); j++) begin
					read_reg(1'b1, b);
					check_byte($sformatf("dout result byte %0d, row %0d", j, i), b, r.res[j]);
				end
			end
			read_reg(1'b0, b);
			check_msr($sformatf("dout msr after row %0d", i), fdc_msr_t'(b),
				expect_msr(1'b1, 1'b0, 1'b0, 1'b0));
		end

		$display("All checks passed");
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		abort_run($sformatf("timeout, the command table did not finish within %0d ns",
			TIMEOUT_NS));
	end

endmodule

// File: all.f
+incdir+design
design/fdc_pkg.sv
design/fdc_stream_if.sv
design/fdc_host_port.sv
design/fdc_cmd_decode.sv
design/fdc_exec.sv
design/fdc_result.sv
design/fdc_top.sv
tb/fdc_clk_gen.sv
tb/fdc_tb.sv

// File: run.sh
#!/bin/sh
# builds the FDC testbench with Verilator and runs it
# exit status is 0 only when the log holds the pass message

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module fdc_tb -f all.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vfdc_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit 1
fi

if grep -q "All checks passed" "$SIM_LOG"; then
	exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1
